//--- rtl/alu.sv
`timescale 1ns/10ps

module alu
(
    input  cpu_isa_pkg::alu_op_e op,
    input  cpu_isa_pkg::word_t   a,
    input  cpu_isa_pkg::word_t   b,
    output cpu_isa_pkg::word_t   y
);
    import cpu_isa_pkg::*;

    always_comb
    begin
        case (op)
            alu_and:
                y = a & b;
            alu_eor:
                y = a ^ b;
            alu_sub:
                y = a - b;
            alu_rsb:
                y = b - a;  // reverse subtract
            alu_add:
                y = a + b;
            alu_orr:
                y = a | b;
            alu_mov:
                y = b;
            alu_bic:
                y = a & ~b;
            alu_mvn:
                y = ~b;
            default:
                y = '0;  // adc sbc rsc and compares
        endcase
    end

endmodule

//--- rtl/cpu_isa_pkg.sv
package cpu_isa_pkg;

`include "cpu_settings.svh"

    // data and instruction word
    typedef logic [`CPU_DATA_W-1:0] word_t;

    // register number as encoded in the instruction
    typedef logic [`CPU_REG_W-1:0] reg_idx_t;

    // data-processing opcodes, encoding of instruction bits 24:21
    // adc, sbc, rsc and the compares are not computed
    typedef enum logic [3:0]
    {
        alu_and = 4'h0,
        alu_eor = 4'h1,
        alu_sub = 4'h2,
        alu_rsb = 4'h3,
        alu_add = 4'h4,
        alu_orr = 4'hc,
        alu_mov = 4'hd,
        alu_bic = 4'he,
        alu_mvn = 4'hf
    } alu_op_e;

    // instruction bits 27:25
    typedef enum logic [2:0]
    {
        dp_reg = 3'b000,  // data processing, register operand
        dp_imm = 3'b001,  // data processing, 8-bit immediate
        ls_imm = 3'b010   // load/store, 12-bit offset
    } instr_class_e;

endpackage

//--- rtl/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

`include "cpu_settings.svh"

    import cpu_isa_pkg::*;

    // per-instruction control, all zero means bubble
    typedef struct packed
    {
        alu_op_e alu_op;
        logic    use_imm;    // operand b from the immediate
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_byte;   // byte access instead of word
    } ctrl_t;

    localparam ctrl_t ctrl_bubble = '0;

    typedef struct packed
    {
        ctrl_t    ctrl;
        word_t    operand_a;
        word_t    operand_b;
        word_t    store_data;
        reg_idx_t dest;
    } id_ex_t;

    typedef struct packed
    {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t dest;
    } ex_mem_t;

    typedef struct packed
    {
        logic     reg_write;
        reg_idx_t dest;
        word_t    result;
    } mem_wb_t;

    // operand source picked in decode
    typedef enum logic [1:0]
    {
        fwd_rf  = 2'd0,
        fwd_ex  = 2'd1,
        fwd_mem = 2'd2,
        fwd_wb  = 2'd3
    } fwd_sel_e;

endpackage

//--- rtl/cpu_pipeline.sv
`timescale 1ns/10ps

`include "cpu_settings.svh"

module cpu_pipeline
(
    input  logic                  clk,
    input  logic                  arst_n,
    output cpu_isa_pkg::word_t    imem_addr,
    input  cpu_isa_pkg::word_t    imem_data,
    output logic                  wb_valid,
    output cpu_isa_pkg::reg_idx_t wb_dest,
    output cpu_isa_pkg::word_t    wb_data
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    word_t    pc;
    word_t    if_id_instr;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;

    ctrl_t    dec_ctrl;
    reg_idx_t dec_rn;
    reg_idx_t dec_rm;
    reg_idx_t dec_rd;
    logic     uses_rn;
    logic     uses_rm;
    logic     uses_rd;
    word_t    dec_imm;

    word_t    rf_a;
    word_t    rf_b;
    word_t    rf_c;
    logic     stall;
    fwd_sel_e sel_a;
    fwd_sel_e sel_b;
    fwd_sel_e sel_c;
    word_t    opnd_a;
    word_t    opnd_b;
    word_t    opnd_c;

    word_t    ex_result;
    word_t    dmem_addr;
    word_t    mem_rdata;
    word_t    mem_result;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t rf_val,
                                      input word_t ex_val, input word_t mem_val,
                                      input word_t wb_val);
        case (sel)
            fwd_ex:  return ex_val;
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    decode_unit decode_unit_inst
    (
        .instr   (if_id_instr),
        .ctrl    (dec_ctrl),
        .rn      (dec_rn),
        .rm      (dec_rm),
        .rd      (dec_rd),
        .uses_rn (uses_rn),
        .uses_rm (uses_rm),
        .uses_rd (uses_rd),
        .imm     (dec_imm)
    );

    reg_file reg_file_inst
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_a_idx (dec_rn),
        .rd_b_idx (dec_rm),
        .rd_c_idx (dec_rd),
        .rd_a     (rf_a),
        .rd_b     (rf_b),
        .rd_c     (rf_c),
        .wr_en    (mem_wb.reg_write),
        .wr_idx   (mem_wb.dest),
        .wr_data  (mem_wb.result)
    );

    hazard_unit hazard_unit_inst
    (
        .dec_rn   (dec_rn),
        .dec_rm   (dec_rm),
        .dec_rd   (dec_rd),
        .uses_rn  (uses_rn),
        .uses_rm  (uses_rm),
        .uses_rd  (uses_rd),
        .ex_ctrl  (id_ex.ctrl),
        .mem_ctrl (ex_mem.ctrl),
        .wb_write (mem_wb.reg_write),
        .ex_dest  (id_ex.dest),
        .mem_dest (ex_mem.dest),
        .wb_dest  (mem_wb.dest),
        .stall    (stall),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .sel_c    (sel_c)
    );

    // each operand has its own source
    assign opnd_a = fwd_mux(sel_a, rf_a, ex_result, mem_result, mem_wb.result);
    assign opnd_b = fwd_mux(sel_b, rf_b, ex_result, mem_result, mem_wb.result);
    assign opnd_c = fwd_mux(sel_c, rf_c, ex_result, mem_result, mem_wb.result);

    alu alu_inst
    (
        .op (id_ex.ctrl.alu_op),
        .a  (id_ex.operand_a),
        .b  (id_ex.operand_b),
        .y  (ex_result)
    );

    // address only moves when the memory stage really accesses the ram
    assign dmem_addr = (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write) ?
                       ex_mem.alu_result : '0;

    data_ram data_ram_inst
    (
        .clk     (clk),
        .addr    (dmem_addr),
        .wdata   (ex_mem.store_data),
        .we      (ex_mem.ctrl.mem_write),
        .byte_en (ex_mem.ctrl.mem_byte),
        .rdata   (mem_rdata)
    );

    assign mem_result = ex_mem.ctrl.mem_read ? mem_rdata : ex_mem.alu_result;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc          <= `CPU_RESET_PC;
            if_id_instr <= '0;
            id_ex       <= '0;
            ex_mem      <= '0;
            mem_wb      <= '0;
        end
        else
        begin
            if (!stall)  // fetch holds during a load-use stall
            begin
                pc          <= pc + 32'd4;
                if_id_instr <= imem_data;
            end

            id_ex.ctrl       <= stall ? ctrl_bubble : dec_ctrl;
            id_ex.operand_a  <= opnd_a;
            id_ex.operand_b  <= dec_ctrl.use_imm ? dec_imm : opnd_b;
            id_ex.store_data <= opnd_c;
            id_ex.dest       <= dec_rd;

            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_result <= ex_result;
            ex_mem.store_data <= id_ex.store_data;
            ex_mem.dest       <= id_ex.dest;

            mem_wb.reg_write <= ex_mem.ctrl.reg_write;
            mem_wb.dest      <= ex_mem.dest;
            mem_wb.result    <= mem_result;
        end
    end

    assign imem_addr = pc;
    assign wb_valid  = mem_wb.reg_write;
    assign wb_dest   = mem_wb.dest;
    assign wb_data   = mem_wb.result;

endmodule

//--- rtl/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and instruction word width
`define CPU_DATA_W 32

// register index width, 16 architectural registers
`define CPU_REG_W 4

// data memory size in bytes, byte addressed
`define CPU_DMEM_BYTES 256

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

//--- rtl/data_ram.sv
`timescale 1ns/10ps

`include "cpu_settings.svh"

module data_ram
(
    input  logic               clk,
    input  cpu_isa_pkg::word_t addr,
    input  cpu_isa_pkg::word_t wdata,
    input  logic               we,
    input  logic               byte_en,
    output cpu_isa_pkg::word_t rdata
);
    import cpu_isa_pkg::*;

    localparam int addr_w = $clog2(`CPU_DMEM_BYTES);

    logic [7:0]        mem [`CPU_DMEM_BYTES];
    logic [addr_w-1:0] a0;
    logic [addr_w-1:0] a1;
    logic [addr_w-1:0] a2;
    logic [addr_w-1:0] a3;

    assign a0 = addr[addr_w-1:0];  // wraps around the array
    assign a1 = a0 + 1'b1;
    assign a2 = a0 + 2'd2;
    assign a3 = a0 + 2'd3;

    // big-endian, msb at the lowest address
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            if (byte_en)
            begin
                mem[a0] <= wdata[7:0];
            end
            else
            begin
                mem[a0] <= wdata[31:24];
                mem[a1] <= wdata[23:16];
                mem[a2] <= wdata[15:8];
                mem[a3] <= wdata[7:0];
            end
        end
    end

    assign rdata = byte_en ? word_t'(mem[a0]) : {mem[a0], mem[a1], mem[a2], mem[a3]};

    // the pipeline parks addr at zero when no access is in the memory stage
    word_aligned: assert property (@(posedge clk) !byte_en |-> (addr[1:0] == 2'b00));
    addr_in_range: assert property (@(posedge clk) addr < `CPU_DMEM_BYTES);

endmodule

//--- rtl/decode_unit.sv
`timescale 1ns/10ps

module decode_unit
(
    input  cpu_isa_pkg::word_t    instr,
    output cpu_pipe_pkg::ctrl_t   ctrl,
    output cpu_isa_pkg::reg_idx_t rn,
    output cpu_isa_pkg::reg_idx_t rm,
    output cpu_isa_pkg::reg_idx_t rd,
    output logic                  uses_rn,
    output logic                  uses_rm,
    output logic                  uses_rd,
    output cpu_isa_pkg::word_t    imm
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    instr_class_e cls;
    logic [3:0]   opcode;
    logic         is_compare;
    logic         is_load;

    assign cls        = instr_class_e'(instr[27:25]);
    assign opcode     = instr[24:21];
    assign is_compare = (opcode[3:2] == 2'b10);  // tst teq cmp cmn
    assign is_load    = instr[20];               // L bit

    // field positions are fixed, only the uses_* flags qualify them
    assign rn = instr[19:16];
    assign rd = instr[15:12];
    assign rm = instr[3:0];

    always_comb
    begin
        ctrl    = ctrl_bubble;
        uses_rn = 1'b0;
        uses_rm = 1'b0;
        uses_rd = 1'b0;
        imm     = '0;

        if (instr != '0)  // zero word is a nop
        begin
            case (cls)
                dp_reg, dp_imm:
                begin
                    ctrl.alu_op    = alu_op_e'(opcode);
                    ctrl.use_imm   = (cls == dp_imm);
                    ctrl.reg_write = !is_compare;
                    uses_rn = (opcode != alu_mov) && (opcode != alu_mvn);
                    uses_rm = (cls == dp_reg);
                    imm     = word_t'(instr[7:0]);  // rotate field ignored
                end
                ls_imm:
                begin
                    // U bit picks the direction of the offset
                    ctrl.alu_op    = instr[23] ? alu_add : alu_sub;
                    ctrl.use_imm   = 1'b1;
                    ctrl.mem_byte  = instr[22];
                    ctrl.mem_read  = is_load;
                    ctrl.mem_write = !is_load;
                    ctrl.reg_write = is_load;
                    uses_rn = 1'b1;  // base register
                    uses_rd = !is_load;  // store data
                    imm     = word_t'(instr[11:0]);
                end
                default:
                begin
                    ctrl = ctrl_bubble;  // unsupported class
                end
            endcase
        end
    end

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit
(
    input  cpu_isa_pkg::reg_idx_t  dec_rn,
    input  cpu_isa_pkg::reg_idx_t  dec_rm,
    input  cpu_isa_pkg::reg_idx_t  dec_rd,
    input  logic                   uses_rn,
    input  logic                   uses_rm,
    input  logic                   uses_rd,
    input  cpu_pipe_pkg::ctrl_t    ex_ctrl,
    input  cpu_pipe_pkg::ctrl_t    mem_ctrl,
    input  logic                   wb_write,
    input  cpu_isa_pkg::reg_idx_t  ex_dest,
    input  cpu_isa_pkg::reg_idx_t  mem_dest,
    input  cpu_isa_pkg::reg_idx_t  wb_dest,
    output logic                   stall,
    output cpu_pipe_pkg::fwd_sel_e sel_a,
    output cpu_pipe_pkg::fwd_sel_e sel_b,
    output cpu_pipe_pkg::fwd_sel_e sel_c
);
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;

    // youngest producer wins
    function automatic fwd_sel_e pick(input reg_idx_t src, input logic used);
        if (!used)
            return fwd_rf;
        else if (ex_ctrl.reg_write && (ex_dest == src))
            return fwd_ex;
        else if (mem_ctrl.reg_write && (mem_dest == src))
            return fwd_mem;
        else if (wb_write && (wb_dest == src))
            return fwd_wb;
        else
            return fwd_rf;
    endfunction

    always_comb
    begin
        sel_a = pick(dec_rn, uses_rn);
        sel_b = pick(dec_rm, uses_rm);
        sel_c = pick(dec_rd, uses_rd);

        // load data only exists one stage later, so hold decode for a cycle
        stall = ex_ctrl.mem_read &&
                ((uses_rn && (dec_rn == ex_dest)) ||
                 (uses_rm && (dec_rm == ex_dest)) ||
                 (uses_rd && (dec_rd == ex_dest)));

        if (stall)
        begin
            // the load in execute is also the one that writes ex_dest
            stall_on_load: assert (ex_ctrl.mem_read && ex_ctrl.reg_write &&
                                   !ex_ctrl.mem_write);
        end
    end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/10ps

`include "cpu_settings.svh"

module reg_file
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  cpu_isa_pkg::reg_idx_t rd_a_idx,
    input  cpu_isa_pkg::reg_idx_t rd_b_idx,
    input  cpu_isa_pkg::reg_idx_t rd_c_idx,
    output cpu_isa_pkg::word_t    rd_a,
    output cpu_isa_pkg::word_t    rd_b,
    output cpu_isa_pkg::word_t    rd_c,
    input  logic                  wr_en,
    input  cpu_isa_pkg::reg_idx_t wr_idx,
    input  cpu_isa_pkg::word_t    wr_data
);
    import cpu_isa_pkg::*;

    localparam int num_regs = 1 << `CPU_REG_W;

    word_t regs [num_regs];

    // r15 is a plain register, there is no branch logic behind it
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < num_regs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    // read is asynchronous, same-cycle write goes through the wb forward
    assign rd_a = regs[rd_a_idx];
    assign rd_b = regs[rd_b_idx];
    assign rd_c = regs[rd_c_idx];

    wr_en_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(wr_en));

endmodule

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu -Mdir obj_dir -f src.f

./obj_dir/Vtb_cpu 2>&1 | tee sim.log

if grep -q "^TESTBENCH PASSED$" sim.log
then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1

//--- src.f
+incdir+rtl
rtl/cpu_isa_pkg.sv
rtl/cpu_pipe_pkg.sv
rtl/decode_unit.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/alu.sv
rtl/data_ram.sv
rtl/cpu_pipeline.sv
tests/tb_clock.sv
tests/tb_cpu.sv

//--- tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock
#(
    parameter int half_period = 10  // 20 ns clock
)
(
    input  logic reset_req,
    output logic clk,
    output logic arst_n
);
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #half_period clk = ~clk;
        end
    end

    // two cycles of reset at start, then again whenever one is requested
    initial
    begin
        arst_n = 1'b0;
        forever
        begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            arst_n = 1'b1;
            wait (reset_req);
            @(negedge clk);
            arst_n = 1'b0;
        end
    end

endmodule

//--- tests/tb_cpu.sv
`timescale 1ns/10ps

`include "cpu_settings.svh"

module tb_cpu;
    import cpu_isa_pkg::*;

    logic       clk;
    logic       arst_n;
    logic       reset_req = 1'b0;
    word_t      imem_addr;
    word_t      imem_data = '0;
    logic       wb_valid;
    reg_idx_t   wb_dest;
    word_t      wb_data;

    word_t      prog [128];
    int         prog_len;
    word_t      m_regs [16];       // model register file
    logic [7:0] m_mem [256];       // model data memory, kept across tests like the ram
    reg_idx_t   exp_dest [256];
    word_t      exp_data [256];
    int         exp_count;
    int         wb_seen;           // head of the expected queue
    reg_idx_t   head_dest;
    word_t      head_data;
    word_t      prev_addr;
    logic       prev_valid;
    int         fetch_repeats;
    int         errors;
    int         errors_at_start;
    int         tests_run;
    int         tests_failed;
    alu_op_e    dp_ops [9];
    alu_op_e    mix_ops [7];       // ops that read both operands

    tb_clock tb_clock_inst
    (
        .reset_req (reset_req),
        .clk       (clk),
        .arst_n    (arst_n)
    );

    cpu_pipeline cpu_pipeline_inst
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_valid  (wb_valid),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data)
    );

    function automatic word_t instr_at(input word_t addr);
        if ((addr >> 2) < word_t'(prog_len))
            return prog[addr[8:2]];
        else
            return '0;  // past the end reads as nop
    endfunction

    always @(negedge clk)
    begin
        imem_data <= instr_at(imem_addr);
    end

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_seen       <= 0;
            prev_addr     <= '0;
            prev_valid    <= 1'b0;
            fetch_repeats <= 0;
        end
        else
        begin
            if (wb_valid)
                wb_seen <= wb_seen + 1;
            if (prev_valid && (imem_addr == prev_addr))
                fetch_repeats <= fetch_repeats + 1;  // fetch held by a stall
            prev_addr  <= imem_addr;
            prev_valid <= 1'b1;
        end
    end

    assign head_dest = exp_dest[wb_seen[7:0]];
    assign head_data = exp_data[wb_seen[7:0]];

    reset_quiet: assert property (@(posedge clk) (!arst_n || $rose(arst_n)) |-> !wb_valid)
    else
    begin
        errors++;
        $display("error: wb_valid expected %h actual %h", 1'b0, $sampled(wb_valid));
    end

    reset_pc: assert property (@(posedge clk)
        (!arst_n || $rose(arst_n)) |-> (imem_addr == `CPU_RESET_PC))
    else
    begin
        errors++;
        $display("error: imem_addr expected %h actual %h", `CPU_RESET_PC,
                 $sampled(imem_addr));
    end

    wb_expected: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> (wb_seen < exp_count))
    else
    begin
        errors++;
        $display("writeback to r%0d arrived with no instruction left to retire",
                 $sampled(wb_dest));
    end

    wb_dest_ok: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_valid && (wb_seen < exp_count)) |-> (wb_dest == head_dest))
    else
    begin
        errors++;
        $display("error: wb_dest expected %h actual %h", $sampled(head_dest),
                 $sampled(wb_dest));
    end

    wb_data_ok: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_valid && (wb_seen < exp_count)) |-> (wb_data == head_data))
    else
    begin
        errors++;
        $display("error: wb_data expected %h actual %h", $sampled(head_data),
                 $sampled(wb_data));
    end

    function automatic word_t reg_form(input logic [3:0] op, input reg_idx_t rd,
                                       input reg_idx_t rn, input reg_idx_t rm);
        return {4'he, 3'b000, op, 1'b0, rn, rd, 8'h00, rm};
    endfunction

    function automatic word_t imm_form(input logic [3:0] op, input reg_idx_t rd,
                                       input reg_idx_t rn, input logic [7:0] imm);
        return {4'he, 3'b001, op, 1'b0, rn, rd, 4'h0, imm};
    endfunction

    // pre-indexed, no writeback of the base
    function automatic word_t mem_form(input logic load, input logic byte_sel,
                                       input logic up, input reg_idx_t rd,
                                       input reg_idx_t rn, input logic [11:0] off);
        return {4'he, 3'b010, 1'b1, up, byte_sel, 1'b0, load, rn, rd, off};
    endfunction

    function automatic logic [7:0] random_byte();
        return 8'($urandom);
    endfunction

    function automatic word_t expected_alu(input logic [3:0] op, input word_t a,
                                           input word_t b);
        case (op)
            4'h0:    return a & b;
            4'h1:    return a ^ b;
            4'h2:    return a - b;
            4'h3:    return b - a;
            4'h4:    return a + b;
            4'hc:    return a | b;
            4'hd:    return b;
            4'he:    return a & ~b;
            4'hf:    return ~b;
            default: return '0;
        endcase
    endfunction

    task automatic emit(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic emit_nops(input int n);
        for (int i = 0; i < n; i++)
            emit('0);
    endtask

    task automatic expect_write(input reg_idx_t rd, input word_t v);
        m_regs[rd]          = v;
        exp_dest[exp_count] = rd;
        exp_data[exp_count] = v;
        exp_count++;
    endtask

    // in-order reference execution of the whole program
    task automatic golden_run();
        word_t      w;
        word_t      a;
        word_t      b;
        word_t      addr;
        logic [7:0] ba;
        reg_idx_t   rn;
        reg_idx_t   rd;
        logic [3:0] op;
        for (int i = 0; i < prog_len; i++)
        begin
            w  = prog[i];
            op = w[24:21];
            rn = w[19:16];
            rd = w[15:12];
            if (w == '0)
                continue;
            if (w[27:26] == 2'b00)
            begin
                a = m_regs[rn];
                b = w[25] ? {24'h0, w[7:0]} : m_regs[w[3:0]];
                if (op[3:2] != 2'b10)  // compares leave registers alone
                    expect_write(rd, expected_alu(op, a, b));
            end
            else if (w[27:25] == 3'b010)
            begin
                addr = w[23] ? m_regs[rn] + {20'h0, w[11:0]} : m_regs[rn] - {20'h0, w[11:0]};
                ba   = addr[7:0];
                if (w[20] && w[22])
                    expect_write(rd, {24'h0, m_mem[ba]});
                else if (w[20])
                    expect_write(rd, {m_mem[ba], m_mem[ba + 8'd1], m_mem[ba + 8'd2],
                                      m_mem[ba + 8'd3]});
                else if (w[22])
                    m_mem[ba] = m_regs[rd][7:0];
                else
                    {m_mem[ba], m_mem[ba + 8'd1], m_mem[ba + 8'd2], m_mem[ba + 8'd3]} =
                        m_regs[rd];
            end
        end
    endtask

    task automatic start_test();
        int n;
        n               = 0;
        errors_at_start = errors;
        reset_req       = 1'b1;
        while ((arst_n === 1'b1) && (n < 10))
        begin
            @(negedge clk);
            n++;
        end
        reset_req = 1'b0;
        if (arst_n === 1'b1)
        begin
            errors++;
            $display("timeout while waiting for reset to assert");
        end
        prog_len  = 0;
        exp_count = 0;
        for (int i = 0; i < 16; i++)
            m_regs[i] = '0;
    endtask

    task automatic end_test(input string name, input int exp_repeats);
        int n;
        golden_run();
        n = 0;
        while ((arst_n !== 1'b1) && (n < 10))
        begin
            @(negedge clk);
            n++;
        end
        if (arst_n !== 1'b1)
        begin
            errors++;
            $display("timeout while waiting for reset to release");
        end
        n = 0;
        while ((wb_seen < exp_count) && (n < 500))
        begin
            @(negedge clk);
            n++;
        end
        if (wb_seen < exp_count)
        begin
            errors++;
            $display("timeout in %s, only %0d of %0d writebacks arrived", name, wb_seen,
                     exp_count);
        end
        repeat (6) @(negedge clk);  // room for stray writebacks
        stall_cycles: assert (fetch_repeats == exp_repeats)
        else
        begin
            errors++;
            $display("error: imem_addr repeats expected %h actual %h", exp_repeats,
                     fetch_repeats);
        end
        tests_run++;
        if (errors != errors_at_start)
        begin
            tests_failed++;
            $display("test %s: fail", name);
        end
        else
        begin
            $display("test %s: pass", name);
        end
    endtask

    task automatic independent_ops_test();
        start_test();
        emit(imm_form(alu_mov, 4'd1, 4'd0, random_byte()));
        emit(imm_form(alu_mvn, 4'd2, 4'd0, random_byte()));  // wide value in r2
        emit_nops(3);
        for (int i = 0; i < 9; i++)
        begin
            emit(imm_form(dp_ops[i], reg_idx_t'(3 + i), 4'd1, random_byte()));
            emit_nops(1);
            emit(reg_form(dp_ops[i], reg_idx_t'(3 + i), 4'd1, 4'd2));
            emit_nops(1);
        end
        emit(reg_form(4'ha, 4'd12, 4'd1, 4'd2));  // cmp
        emit(imm_form(4'h8, 4'd13, 4'd1, 8'h0f));  // tst
        emit_nops(1);
        end_test("independent ops", 0);
    endtask

    task automatic forwarding_test();
        int         p;
        int         q;
        int         rd;
        int         off;
        logic [3:0] cop;
        start_test();
        for (int r = 9; r < 15; r++)
            emit(imm_form(alu_mov, reg_idx_t'(r), 4'd0, random_byte()));
        emit_nops(3);
        for (int rep = 0; rep < 2; rep++)
        begin
            for (int gap = 0; gap < 3; gap++)
            begin
                for (int side = 0; side < 3; side++)
                begin
                    p   = 1 + $urandom_range(5);
                    q   = 9 + $urandom_range(5);
                    rd  = 7 + $urandom_range(1);
                    cop = mix_ops[$urandom_range(6)];
                    off = 4 * $urandom_range(63);
                    emit(imm_form(dp_ops[$urandom_range(8)], reg_idx_t'(p), reg_idx_t'(q),
                                  random_byte()));
                    emit_nops(gap);  // 0 ex, 1 mem, 2 wb
                    if (side == 0)
                    begin
                        emit(reg_form(cop, reg_idx_t'(rd), reg_idx_t'(p), reg_idx_t'(q)));
                    end
                    else if (side == 1)
                    begin
                        emit(reg_form(cop, reg_idx_t'(rd), reg_idx_t'(q), reg_idx_t'(p)));
                    end
                    else
                    begin
                        // store data path, read back with r0 as base
                        emit(mem_form(1'b0, 1'b0, 1'b1, reg_idx_t'(p), 4'd0, 12'(off)));
                        emit(mem_form(1'b1, 1'b0, 1'b1, reg_idx_t'(rd), 4'd0, 12'(off)));
                    end
                    emit_nops(3);
                end
            end
        end
        end_test("forwarding chains", 0);
    endtask

    task automatic load_use_test();
        start_test();
        emit(imm_form(alu_mov, 4'd1, 4'd0, 8'h40));
        emit(imm_form(alu_mvn, 4'd2, 4'd0, random_byte()));
        emit_nops(3);
        emit(mem_form(1'b0, 1'b0, 1'b1, 4'd2, 4'd1, 12'd12));
        emit(mem_form(1'b1, 1'b0, 1'b1, 4'd3, 4'd1, 12'd12));
        emit(reg_form(alu_add, 4'd4, 4'd3, 4'd2));  // needs r3 straight from the load
        emit_nops(2);
        end_test("load use stall", 1);
    endtask

    task automatic memory_test();
        int   off;
        int   boff;
        int   bsel;
        logic up;
        start_test();
        emit(imm_form(alu_mov, 4'd1, 4'd0, 8'h80));  // base in the middle of the ram
        emit(imm_form(alu_mvn, 4'd2, 4'd0, random_byte()));
        emit(imm_form(alu_eor, 4'd2, 4'd2, random_byte()));
        emit(imm_form(alu_mov, 4'd3, 4'd0, random_byte()));
        emit_nops(1);
        for (int i = 0; i < 4; i++)
        begin
            up   = i[0];  // both offset directions
            off  = up ? 4 * $urandom_range(31) : 4 + 4 * $urandom_range(31);
            bsel = $urandom_range(3);
            boff = up ? off + bsel : off - bsel;
            emit(mem_form(1'b0, 1'b0, up, 4'd2, 4'd1, 12'(off)));   // str
            emit(mem_form(1'b1, 1'b1, up, 4'd4, 4'd1, 12'(boff)));  // ldrb inside the word
            emit(mem_form(1'b1, 1'b0, up, 4'd5, 4'd1, 12'(off)));   // ldr
            emit(mem_form(1'b0, 1'b1, up, 4'd3, 4'd1, 12'(boff)));  // strb
            emit(mem_form(1'b1, 1'b0, up, 4'd6, 4'd1, 12'(off)));   // ldr with one byte changed
            emit(imm_form(alu_add, 4'd2, 4'd2, random_byte()));
        end
        emit_nops(2);
        end_test("load store", 0);
    endtask

    initial
    begin
        void'($urandom(49840));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        prog_len     = 0;
        exp_count    = 0;
        dp_ops       = '{alu_and, alu_eor, alu_sub, alu_rsb, alu_add, alu_orr, alu_mov,
                         alu_bic, alu_mvn};
        mix_ops      = '{alu_and, alu_eor, alu_sub, alu_rsb, alu_add, alu_orr, alu_bic};
        @(negedge clk);

        start_test();
        end_test("reset", 0);
        independent_ops_test();
        forwarding_test();
        load_use_test();
        memory_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
